// ==== logic/aud_params.svh ====
`ifndef AUD_PARAMS_SVH
`define AUD_PARAMS_SVH

// external SRAM is 1M x 16
`define AUD_ADDR_W 20
`define AUD_DATA_W 16

// speed factor input, 1 to 8
`define AUD_SPEED_W 4
`define AUD_MAX_SPEED 8

`endif

// ==== logic/aud_mem_pkg.sv ====
`default_nettype none
`include "aud_params.svh"

package aud_mem_pkg;

	// one signed audio sample per SRAM word
	typedef logic signed [`AUD_DATA_W-1:0] sample_t;

	typedef logic [`AUD_ADDR_W-1:0] addr_t;

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} sram_op_t;

endpackage

`default_nettype wire

// ==== logic/aud_ctrl_pkg.sv ====
`default_nettype none

package aud_ctrl_pkg;

	// fast skips addresses, slow modes repeat or step toward the next sample
	typedef enum logic [1:0] {
		MODE_FAST,
		MODE_SLOW_HOLD,
		MODE_SLOW_LERP
	} play_mode_t;

	typedef enum logic [1:0] {
		DSP_IDLE,
		DSP_FETCH,
		DSP_SEND
	} dsp_state_t;

	typedef enum logic [1:0] {
		REC_IDLE,
		REC_SHIFT,
		REC_WRITE
	} rec_state_t;

endpackage

`default_nettype wire

// ==== logic/sram_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface sram_if;
	import aud_mem_pkg::*;

	// req is a level, held with its fields until gnt
	logic     req;
	sram_op_t op;
	addr_t    addr;
	sample_t  wdata;

	// gnt is combinational, rdata valid in the granted cycle
	logic     gnt;
	sample_t  rdata;

	modport client (
		output req, op, addr, wdata,
		input  gnt, rdata
	);

	modport arbiter (
		input  req, op, addr, wdata,
		output gnt, rdata
	);

endinterface

`default_nettype wire

// ==== logic/sram_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_arbiter (
	input  wire                        i_clk,
	input  wire                        i_rst_n,
	sram_if.arbiter                    rec,
	sram_if.arbiter                    dsp,
	output aud_mem_pkg::addr_t         o_sram_addr,
	output logic                       o_sram_we_n,
	output aud_mem_pkg::sample_t       o_sram_wdata,
	input  wire aud_mem_pkg::sample_t  i_sram_rdata
);
	localparam int MAX_RUN = 4;

	logic [2:0] rec_run;
	logic       rec_win;
	logic       dsp_win;

	// recorder first, but the engine gets one slot after a run of four
	assign rec_win = rec.req && !(dsp.req && rec_run == 3'(MAX_RUN));
	assign dsp_win = dsp.req && !rec_win;

	assign rec.gnt   = rec_win;
	assign dsp.gnt   = dsp_win;
	assign rec.rdata = i_sram_rdata;
	assign dsp.rdata = i_sram_rdata;

	always_comb begin
		if (rec_win) begin
			o_sram_addr  = rec.addr;
			o_sram_wdata = rec.wdata;
			o_sram_we_n  = (rec.op != aud_mem_pkg::OP_WRITE);
		end else begin
			o_sram_addr  = dsp.addr;
			o_sram_wdata = dsp.wdata;
			o_sram_we_n  = !(dsp_win && dsp.op == aud_mem_pkg::OP_WRITE);
		end
	end

	// back-to-back recorder grants, saturating
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			rec_run <= '0;
		end else if (rec_win) begin
			if (rec_run != 3'(MAX_RUN))
				rec_run <= rec_run + 1'b1;
		end else begin
			rec_run <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/aud_recorder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "aud_params.svh"

module aud_recorder (
	input  wire                 i_clk,
	input  wire                 i_rst_n,
	input  wire                 i_adc_dat,
	input  wire                 i_adclrck,
	input  wire                 i_rec_start,
	input  wire                 i_rec_stop,
	sram_if.client              mem,
	output aud_mem_pkg::addr_t  o_rec_count
);
	import aud_mem_pkg::*;
	import aud_ctrl_pkg::*;

	localparam int DW = `AUD_DATA_W;
	localparam int BW = $clog2(DW);

	rec_state_t    state;
	logic          lrck_q;
	logic          lrck_rise;
	logic          shift_en;
	logic          full_next;
	logic [BW-1:0] bit_cnt;
	sample_t       shreg;

	assign lrck_rise = i_adclrck && !lrck_q;
	// MSB arrives with the lrck rise, the rest follow on each bit clock
	assign shift_en  = (state == REC_SHIFT) && (lrck_rise || bit_cnt != '0);
	assign full_next = &(o_rec_count + 1'b1);

	// write address is the count of words already stored
	assign mem.req   = (state == REC_WRITE);
	assign mem.op    = OP_WRITE;
	assign mem.addr  = o_rec_count;
	assign mem.wdata = shreg;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state       <= REC_IDLE;
			lrck_q      <= 1'b0;
			bit_cnt     <= '0;
			o_rec_count <= '0;
		end else begin
			lrck_q <= i_adclrck;
			if (shift_en)
				bit_cnt <= bit_cnt + 1'b1;
			case (state)
				REC_IDLE: begin
					if (i_rec_start) begin
						state       <= REC_SHIFT;
						bit_cnt     <= '0;
						o_rec_count <= '0;
					end
				end
				REC_SHIFT: begin
					if (i_rec_stop)
						state <= REC_IDLE;
					else if (shift_en && bit_cnt == BW'(DW - 1))
						state <= REC_WRITE;
				end
				REC_WRITE: begin
					if (mem.gnt) begin
						o_rec_count <= o_rec_count + 1'b1;
						// memory full stops recording like a stop strobe
						state       <= (i_rec_stop || full_next) ? REC_IDLE : REC_SHIFT;
					end else if (i_rec_stop) begin
						state <= REC_IDLE;
					end
				end
				default: state <= REC_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (shift_en)
			shreg <= {shreg[DW-2:0], i_adc_dat};
	end

endmodule

`default_nettype wire

// ==== logic/aud_dsp.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "aud_params.svh"

module aud_dsp (
	input  wire                            i_clk,
	input  wire                            i_rst_n,
	input  wire                            i_start,
	input  wire                            i_stop,
	input  wire                            i_pause,
	input  wire aud_ctrl_pkg::play_mode_t  i_mode,
	input  wire [`AUD_SPEED_W-1:0]         i_speed,
	input  wire aud_mem_pkg::addr_t        i_rec_count,
	input  wire                            i_daclrck,
	input  wire                            i_sent_finish,
	sram_if.client                         mem,
	output aud_mem_pkg::sample_t           o_dac_data,
	output logic                           o_player_en,
	output logic                           o_finish
);
	import aud_mem_pkg::*;
	import aud_ctrl_pkg::*;

	localparam int SW = `AUD_SPEED_W;
	localparam int AW = `AUD_ADDR_W;
	localparam int DW = `AUD_DATA_W;

	dsp_state_t          state;
	play_mode_t          mode_q;
	logic [SW-1:0]       speed_q;
	logic [SW-1:0]       speed_lim;
	logic [SW-1:0]       rep_cnt;
	logic [1:0]          phase;
	addr_t               rd_addr;
	addr_t               nxt_addr;
	logic [AW:0]         fast_sum;
	logic                at_end;
	logic                rd0_gnt;
	logic                rd1_gnt;
	logic                compute;
	sample_t             cur;
	sample_t             nxt;
	sample_t             step;
	logic signed [DW:0]  diff;
	logic signed [DW:0]  quot;

	// speed 0 plays as 1, anything above the maximum is clipped
	always_comb begin
		if (i_speed == '0)
			speed_lim = SW'(1);
		else if (i_speed > SW'(`AUD_MAX_SPEED))
			speed_lim = SW'(`AUD_MAX_SPEED);
		else
			speed_lim = i_speed;
	end

	assign at_end   = (rd_addr >= i_rec_count);
	// last sample pairs with itself, so its group is flat
	assign nxt_addr = (rd_addr + 1'b1 < i_rec_count) ? rd_addr + 1'b1 : rd_addr;
	assign fast_sum = {1'b0, rd_addr} + speed_q;

	// signed division truncates toward zero
	assign diff = {nxt[DW-1], nxt} - {cur[DW-1], cur};
	assign quot = diff / $signed({1'b0, speed_q});
	assign step = quot[DW-1:0];

	assign rd0_gnt = (state == DSP_FETCH) && (phase == 2'd0) && mem.gnt;
	assign rd1_gnt = (state == DSP_FETCH) && (phase == 2'd1) && mem.gnt;
	assign compute = (state == DSP_FETCH) && (phase == 2'd2);

	assign mem.req   = (state == DSP_FETCH) && (phase != 2'd2) && !(phase == 2'd0 && at_end);
	assign mem.op    = OP_READ;
	assign mem.addr  = (phase == 2'd1) ? nxt_addr : rd_addr;
	assign mem.wdata = '0;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state       <= DSP_IDLE;
			mode_q      <= MODE_FAST;
			speed_q     <= SW'(1);
			rep_cnt     <= '0;
			phase       <= '0;
			rd_addr     <= '0;
			o_player_en <= 1'b0;
			o_finish    <= 1'b0;
		end else begin
			o_finish <= 1'b0;
			if (state != DSP_IDLE && i_stop) begin
				state       <= DSP_IDLE;
				o_player_en <= 1'b0;
				o_finish    <= 1'b1;
			end else begin
				case (state)
					DSP_IDLE: begin
						if (i_start) begin
							state   <= DSP_FETCH;
							mode_q  <= i_mode;
							speed_q <= speed_lim;
							rep_cnt <= '0;
							phase   <= '0;
							rd_addr <= '0;
						end
					end
					DSP_FETCH: begin
						if (phase == 2'd0 && at_end) begin
							state    <= DSP_IDLE;
							o_finish <= 1'b1;
						end else if (rd0_gnt) begin
							if (mode_q == MODE_FAST) begin
								// saturate so a wrap cannot restart the pass
								rd_addr <= fast_sum[AW] ? '1 : fast_sum[AW-1:0];
								state   <= DSP_SEND;
							end else begin
								phase <= 2'd1;
							end
						end else if (rd1_gnt) begin
							phase <= 2'd2;
						end else if (compute) begin
							phase <= 2'd0;
							state <= DSP_SEND;
							if (rep_cnt == speed_q - 1'b1) begin
								rep_cnt <= '0;
								rd_addr <= rd_addr + 1'b1;
							end else begin
								rep_cnt <= rep_cnt + 1'b1;
							end
						end
					end
					DSP_SEND: begin
						// once started, a word runs to the end even if paused
						if (i_sent_finish) begin
							o_player_en <= 1'b0;
							state       <= DSP_FETCH;
						end else if (i_daclrck && !i_pause) begin
							o_player_en <= 1'b1;
						end
					end
					default: state <= DSP_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (rd0_gnt)
			cur <= mem.rdata;
		if (rd1_gnt)
			nxt <= mem.rdata;
		if (rd0_gnt && mode_q == MODE_FAST)
			o_dac_data <= mem.rdata;
		else if (compute && mode_q == MODE_SLOW_LERP && rep_cnt != '0)
			o_dac_data <= o_dac_data + step;
		else if (compute)
			o_dac_data <= cur;
	end

endmodule

`default_nettype wire

// ==== logic/aud_player.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "aud_params.svh"

module aud_player (
	input  wire                        i_clk,
	input  wire                        i_rst_n,
	input  wire                        i_en,
	input  wire aud_mem_pkg::sample_t  i_data,
	output logic                       o_dac_dat,
	output logic                       o_sent_finish
);
	localparam int DW = `AUD_DATA_W;
	localparam int CW = $clog2(DW + 1);

	logic          en_q;
	logic          busy;
	logic [CW-1:0] bit_cnt;
	logic [DW-1:0] shreg;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			en_q          <= 1'b0;
			busy          <= 1'b0;
			bit_cnt       <= '0;
			o_dac_dat     <= 1'b0;
			o_sent_finish <= 1'b0;
		end else begin
			en_q          <= i_en;
			o_sent_finish <= 1'b0;
			if (!i_en) begin
				// dropped enable aborts the word
				busy      <= 1'b0;
				bit_cnt   <= '0;
				o_dac_dat <= 1'b0;
			end else if (!en_q) begin
				busy      <= 1'b1;
				bit_cnt   <= CW'(1);
				o_dac_dat <= i_data[DW-1];
			end else if (busy) begin
				if (bit_cnt == CW'(DW)) begin
					busy          <= 1'b0;
					o_dac_dat     <= 1'b0;
					o_sent_finish <= 1'b1;
				end else begin
					bit_cnt   <= bit_cnt + 1'b1;
					o_dac_dat <= shreg[DW-1];
				end
			end
		end
	end

	// msb goes out directly, the rest waits here
	always_ff @(posedge i_clk) begin
		if (i_en && !en_q)
			shreg <= {i_data[DW-2:0], 1'b0};
		else if (busy)
			shreg <= {shreg[DW-2:0], 1'b0};
	end

endmodule

`default_nettype wire

// ==== logic/aud_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "aud_params.svh"

module aud_core (
	input  wire                            i_clk,
	input  wire                            i_rst_n,
	input  wire                            i_adc_dat,
	input  wire                            i_adclrck,
	input  wire                            i_rec_start,
	input  wire                            i_rec_stop,
	input  wire                            i_play_start,
	input  wire                            i_play_stop,
	input  wire                            i_pause,
	input  wire aud_ctrl_pkg::play_mode_t  i_mode,
	input  wire [`AUD_SPEED_W-1:0]         i_speed,
	input  wire                            i_daclrck,
	output aud_mem_pkg::addr_t             o_sram_addr,
	output logic                           o_sram_we_n,
	output aud_mem_pkg::sample_t           o_sram_wdata,
	input  wire aud_mem_pkg::sample_t      i_sram_rdata,
	output logic                           o_dac_dat,
	output logic                           o_play_finish,
	output aud_mem_pkg::addr_t             o_rec_count
);
	import aud_mem_pkg::*;

	sample_t dac_data;
	logic    player_en;
	logic    sent_finish;

	sram_if rec_bus ();
	sram_if dsp_bus ();

	sram_arbiter u_arbiter (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.rec          (rec_bus.arbiter),
		.dsp          (dsp_bus.arbiter),
		.o_sram_addr  (o_sram_addr),
		.o_sram_we_n  (o_sram_we_n),
		.o_sram_wdata (o_sram_wdata),
		.i_sram_rdata (i_sram_rdata)
	);

	aud_recorder u_recorder (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_adc_dat   (i_adc_dat),
		.i_adclrck   (i_adclrck),
		.i_rec_start (i_rec_start),
		.i_rec_stop  (i_rec_stop),
		.mem         (rec_bus.client),
		.o_rec_count (o_rec_count)
	);

	// playback reads only what has been recorded so far
	aud_dsp u_dsp (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_start       (i_play_start),
		.i_stop        (i_play_stop),
		.i_pause       (i_pause),
		.i_mode        (i_mode),
		.i_speed       (i_speed),
		.i_rec_count   (o_rec_count),
		.i_daclrck     (i_daclrck),
		.i_sent_finish (sent_finish),
		.mem           (dsp_bus.client),
		.o_dac_data    (dac_data),
		.o_player_en   (player_en),
		.o_finish      (o_play_finish)
	);

	aud_player u_player (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_en          (player_en),
		.i_data        (dac_data),
		.o_dac_dat     (o_dac_dat),
		.o_sent_finish (sent_finish)
	);

endmodule

`default_nettype wire

// ==== sim/sram_model.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "aud_params.svh"

module sram_model (
	input  wire                        i_clk,
	input  wire aud_mem_pkg::addr_t    i_addr,
	input  wire                        i_we_n,
	input  wire aud_mem_pkg::sample_t  i_wdata,
	output aud_mem_pkg::sample_t       o_rdata
);
	localparam int DEPTH = 1 << `AUD_ADDR_W;

	logic [`AUD_DATA_W-1:0] mem [0:DEPTH-1];

	// power-up contents follow the address, so stray reads stand out
	initial begin
		for (int a = 0; a < DEPTH; a++)
			mem[a] = a[15:0] ^ a[19:4] ^ 16'h5a3c;
	end

	// asynchronous read
	assign o_rdata = mem[i_addr];

	// write lands at the clock edge that ends the write cycle
	always @(posedge i_clk) begin
		if (!i_we_n)
			mem[i_addr] <= i_wdata;
	end

endmodule

`default_nettype wire

// ==== sim/tb_aud_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "aud_params.svh"

module tb_aud_core;
	import aud_mem_pkg::*;
	import aud_ctrl_pkg::*;

	localparam int DW = `AUD_DATA_W;
	localparam int NREC = 24;
	localparam int LRCK_PERIOD = 32;
	// words of all playback runs, the stopped run counted in full
	localparam int TOTAL_WORDS = 8 + 4 * NREC + 2 * NREC + 8 * NREC + NREC + 4 * NREC + NREC;
	localparam int LIMIT_CYCLES = TOTAL_WORDS * 64 + 4 * NREC * LRCK_PERIOD + 4000;

	logic                    i_clk;
	logic                    i_rst_n;
	logic                    i_adc_dat;
	logic                    i_adclrck;
	logic                    i_rec_start;
	logic                    i_rec_stop;
	logic                    i_play_start;
	logic                    i_play_stop;
	logic                    i_pause;
	play_mode_t              i_mode;
	logic [`AUD_SPEED_W-1:0] i_speed;
	logic                    i_daclrck;
	addr_t                   o_sram_addr;
	logic                    o_sram_we_n;
	sample_t                 o_sram_wdata;
	sample_t                 sram_rdata;
	logic                    o_dac_dat;
	logic                    o_play_finish;
	addr_t                   o_rec_count;

	sample_t rec_src [NREC];
	sample_t exp_q [$];
	sample_t word;
	sample_t exp_word;
	int      seed = 28636;
	int      checks = 0;
	int      value_errs = 0;
	int      other_errs = 0;
	int      words_done = 0;
	int      finish_cnt = 0;
	int      fin_base = 0;
	int      bits_left = 0;
	int      adc_idx = 0;
	int      wr_next = 0;
	bit      en_prev = 1'b0;
	bit      rec_req = 1'b0;
	bit      adc_busy = 1'b0;
	bit      rec_done = 1'b0;

	aud_core dut0 (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_adc_dat     (i_adc_dat),
		.i_adclrck     (i_adclrck),
		.i_rec_start   (i_rec_start),
		.i_rec_stop    (i_rec_stop),
		.i_play_start  (i_play_start),
		.i_play_stop   (i_play_stop),
		.i_pause       (i_pause),
		.i_mode        (i_mode),
		.i_speed       (i_speed),
		.i_daclrck     (i_daclrck),
		.o_sram_addr   (o_sram_addr),
		.o_sram_we_n   (o_sram_we_n),
		.o_sram_wdata  (o_sram_wdata),
		.i_sram_rdata  (sram_rdata),
		.o_dac_dat     (o_dac_dat),
		.o_play_finish (o_play_finish),
		.o_rec_count   (o_rec_count)
	);

	sram_model u_sram (
		.i_clk   (i_clk),
		.i_addr  (o_sram_addr),
		.i_we_n  (o_sram_we_n),
		.i_wdata (o_sram_wdata),
		.o_rdata (sram_rdata)
	);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	task automatic next_cycle();
		@(posedge i_clk);
		#2;
	endtask

	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		checks++;
		if (got !== exp) begin
			value_errs++;
			$display("** Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input addr_t got, input addr_t exp);
		checks++;
		if (got !== exp) begin
			value_errs++;
			$display("** Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic report_problem(input string msg);
		other_errs++;
		$display("Problem at %0d ns: %s", $time, msg);
	endtask

	task automatic finish_run();
		$display("checks %0d, value errors %0d, other errors %0d",
			checks, value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	endtask

	// n-th word of a playback run, built from the recorded samples
	function automatic sample_t expected_word(input play_mode_t mode, input int speed,
		input int n);
		int g;
		int r;
		int cur;
		int nxt;
		int step;
		int val;
		g = n / speed;
		r = n % speed;
		if (mode == MODE_FAST)
			return rec_src[n * speed];
		if (mode == MODE_SLOW_HOLD)
			return rec_src[g];
		cur = rec_src[g];
		// last sample steps toward itself
		nxt = (g + 1 < NREC) ? rec_src[g + 1] : cur;
		step = (nxt - cur) / speed;
		val = cur + r * step;
		return val[DW-1:0];
	endfunction

	// both left/right clocks plus the serial ADC stream
	initial begin : lrck_gen
		int c;
		c = LRCK_PERIOD - 1;
		i_adclrck = 1'b0;
		i_daclrck = 1'b0;
		i_adc_dat = 1'b0;
		i_rec_start = 1'b0;
		i_rec_stop = 1'b0;
		forever begin
			next_cycle();
			c = (c + 1) % LRCK_PERIOD;
			i_adclrck = (c < DW);
			// DAC frame a quarter period behind
			i_daclrck = (((c + 24) % LRCK_PERIOD) < DW);
			i_rec_start = 1'b0;
			i_rec_stop = 1'b0;
			i_adc_dat = (adc_busy && c < DW) ? rec_src[adc_idx][DW - 1 - c] : 1'b0;
			if (c == LRCK_PERIOD - 1) begin
				if (adc_busy) begin
					adc_idx++;
					if (adc_idx == NREC) begin
						adc_busy = 1'b0;
						i_rec_stop = 1'b1;
						rec_done = 1'b1;
					end
				end else if (rec_req) begin
					rec_req = 1'b0;
					adc_busy = 1'b1;
					adc_idx = 0;
					i_rec_start = 1'b1;
				end
			end
		end
	end

	// words framed by the engine's enable to the player
	always @(negedge i_clk) begin
		if (o_play_finish === 1'b1)
			finish_cnt++;
		if (!i_rst_n || dut0.player_en !== 1'b1) begin
			bits_left = 0;
		end else if (!en_prev) begin
			bits_left = DW;
		end else if (bits_left > 0) begin
			word = {word[DW-2:0], o_dac_dat};
			bits_left--;
			if (bits_left == 0) begin
				words_done++;
				if (exp_q.size() == 0) begin
					report_problem("a word came out of o_dac_dat when none was expected");
				end else begin
					exp_word = exp_q.pop_front();
					check_sample("o_dac_dat word", word, exp_word);
				end
			end
		end
		en_prev = i_rst_n && dut0.player_en === 1'b1;
	end

	// each SRAM write carries the next recorded sample to the next address
	always @(negedge i_clk) begin
		if (o_sram_we_n !== 1'b1) begin
			if (o_sram_we_n !== 1'b0 || wr_next >= NREC) begin
				report_problem("o_sram_we_n is unknown or low outside a recording write");
			end else begin
				check_count("o_sram_addr", o_sram_addr, wr_next);
				check_sample("o_sram_wdata", o_sram_wdata, rec_src[wr_next]);
				wr_next++;
			end
		end
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge i_clk);
		report_problem($sformatf("run still busy after %0d cycles", LIMIT_CYCLES));
		finish_run();
	end

	task automatic record_samples();
		int tmp;
		for (int i = 0; i < NREC; i++) begin
			tmp = $random(seed);
			rec_src[i] = tmp[DW-1:0];
		end
		wr_next = 0;
		@(negedge i_clk);
		rec_done = 1'b0;
		rec_req = 1'b1;
	endtask

	task automatic wait_record();
		while (!rec_done)
			@(negedge i_clk);
		repeat (2) next_cycle();
		check_count("o_rec_count", o_rec_count, NREC);
		for (int i = 0; i < NREC; i++)
			check_sample($sformatf("sram[%0d]", i), u_sram.mem[i], rec_src[i]);
	endtask

	task automatic start_play(input play_mode_t mode, input int speed);
		int len;
		len = (mode == MODE_FAST) ? (NREC + speed - 1) / speed : NREC * speed;
		for (int i = 0; i < len; i++)
			exp_q.push_back(expected_word(mode, speed, i));
		fin_base = finish_cnt;
		next_cycle();
		i_mode = mode;
		i_speed = speed[`AUD_SPEED_W-1:0];
		i_play_start = 1'b1;
		next_cycle();
		i_play_start = 1'b0;
	endtask

	task automatic wait_finish(input string what);
		while (finish_cnt == fin_base)
			next_cycle();
		repeat (4) next_cycle();
		if (finish_cnt != fin_base + 1)
			report_problem($sformatf("%s gave more than one o_play_finish pulse", what));
		if (exp_q.size() != 0)
			report_problem($sformatf("%s ended with %0d words missing", what, exp_q.size()));
		exp_q.delete();
	endtask

	task automatic wait_words(input int n);
		int target;
		target = words_done + n;
		while (words_done < target)
			next_cycle();
	endtask

	task automatic pause_for_periods(input int periods);
		int seen;
		next_cycle();
		i_pause = 1'b1;
		seen = words_done;
		repeat (periods * LRCK_PERIOD) next_cycle();
		if (words_done != seen)
			report_problem("words kept coming while i_pause was high");
		i_pause = 1'b0;
	endtask

	task automatic stop_mid_play();
		int seen;
		seen = words_done;
		fin_base = finish_cnt;
		next_cycle();
		i_play_stop = 1'b1;
		next_cycle();
		i_play_stop = 1'b0;
		next_cycle();
		if (finish_cnt != fin_base + 1)
			report_problem("i_play_stop did not give one o_play_finish pulse");
		repeat (4 * LRCK_PERIOD) next_cycle();
		if (words_done != seen)
			report_problem("words kept coming after i_play_stop");
		if (exp_q.size() == 0)
			report_problem("playback was already over when i_play_stop came");
		exp_q.delete();
	endtask

	initial begin
		i_rst_n = 1'b0;
		i_play_start = 1'b0;
		i_play_stop = 1'b0;
		i_pause = 1'b0;
		i_mode = MODE_FAST;
		i_speed = 1;
		repeat (16) @(posedge i_clk);
		#2;
		i_rst_n = 1'b1;
		repeat (4) next_cycle();

		record_samples();
		wait_record();

		start_play(MODE_FAST, 3);
		wait_finish("fast play at speed 3");
		start_play(MODE_SLOW_HOLD, 4);
		wait_finish("slow hold at speed 4");
		start_play(MODE_SLOW_LERP, 2);
		wait_finish("interpolation at speed 2");
		start_play(MODE_SLOW_LERP, 8);
		wait_finish("interpolation at speed 8");

		// pause after a few words, then the rest must follow in order
		start_play(MODE_FAST, 1);
		wait_words(5);
		pause_for_periods(4);
		wait_finish("paused fast play");

		// playback trails a fresh recording
		record_samples();
		while (!adc_busy || adc_idx < 3)
			@(negedge i_clk);
		next_cycle();
		start_play(MODE_SLOW_HOLD, 4);
		wait_finish("slow hold during recording");
		wait_record();

		start_play(MODE_FAST, 1);
		wait_words(4);
		stop_mid_play();

		finish_run();
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+logic
logic/aud_mem_pkg.sv
logic/aud_ctrl_pkg.sv
logic/sram_if.sv
logic/sram_arbiter.sv
logic/aud_recorder.sv
logic/aud_dsp.sv
logic/aud_player.sv
logic/aud_core.sv
sim/sram_model.sv
sim/tb_aud_core.sv
